//--- Bender.yml
package:
  name: axi_to_hdmi

export_include_dirs:
  - common

sources:
  - files:
      - common/link_pkg.sv
      - common/video_pkg.sv
      - common/pixel_ring_if.sv
      - src/link_word_decoder.sv
      - pixel_store/pixel_ring.sv
      - pixel_store/pixel_unpacker.sv
      - src/video_timing_gen.sv
      - src/axi_to_hdmi_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_axi_to_hdmi.sv

//--- common/hdmi_bridge_config.svh
/* build-time constants for the video output bridge
   marker code, word flags, start delay, ring size, default 1080p raster */
`ifndef HDMI_BRIDGE_CONFIG_SVH
`define HDMI_BRIDGE_CONFIG_SVH

// ========================================
// link word encoding
// ========================================
`define HB_MARKER_PATTERN  48'hFEFE_FEFE_FEFE  // upper field of a frame marker
`define HB_FLAG_MARKER     2'b11               // frame marker
`define HB_FLAG_SINGLE     2'b01               // one pixel in 39:16
`define HB_FLAG_DUAL       2'b10               // two pixels, 39:16 then 63:40

// start of raster after first marker, in pixel clocks
`define HB_START_DELAY     32

// ring queue size
`define HB_RING_DEPTH      16
`define HB_RING_AW         4                   // log2 of depth

// ========================================
// default raster, 1920x1080 at 148.5 MHz
// ========================================
`define HB_H_SYNC          44
`define HB_H_BACK          148
`define HB_H_DISP          1920
`define HB_H_FRONT         88
`define HB_H_TOTAL         2200   // sync + back + disp + front

`define HB_V_SYNC          5
`define HB_V_BACK          36
`define HB_V_DISP          1080
`define HB_V_FRONT         4
`define HB_V_TOTAL         1125

`endif

//--- common/link_pkg.sv
/* incoming 64-bit link word format
   word, kind flag and marker field types */
`default_nettype none

package link_pkg;

    // full word from the capture side
    //   63:40 second pixel (dual only)
    //   39:16 first pixel
    //   15:14 kind flag
    //   13:0  unused
    typedef logic [63:0] link_word_t;

    // kind field, bits 15:14
    typedef logic [1:0]  link_flag_t;

    // bits 63:16, compared against the marker pattern
    typedef logic [47:0] marker_t;

endpackage : link_pkg

`default_nettype wire

//--- common/pixel_ring_if.sv
/* link between decoder, ring queue and unpacker
   writer, store and reader modports */
`default_nettype none

interface pixel_ring_if;
    import video_pkg::*;

    // write side
    logic        push;        // qualified, taken only when full is low
    ring_entry_t push_entry;
    logic        full;        // next write pointer hits read pointer

    // frame flush, wins over push and pop
    logic        clear;

    // read side
    ring_entry_t head;        // entry at read pointer
    logic        empty;
    logic        pop;         // taken only when empty is low

    modport writer (
        output push,
        output push_entry,
        output clear,
        input  full
    );

    modport store (
        input  push,
        input  push_entry,
        input  clear,
        input  pop,
        output head,
        output full,
        output empty
    );

    modport reader (
        input  head,
        input  empty,
        input  clear,
        output pop
    );

endinterface : pixel_ring_if

`default_nettype wire

//--- common/video_pkg.sv
/* pixel, raster counter and queue entry types
   plus the raster state encoding */
`default_nettype none

`include "hdmi_bridge_config.svh"

package video_pkg;

    typedef logic [23:0] rgb_t;         // rgb888, r in 23:16
    typedef logic [11:0] coord_t;       // h and v raster counters, up to 4095

    // one queued link word, flag kept so the reader knows how many pixels
    typedef struct packed {
        rgb_t                 second;   // valid for dual words only
        rgb_t                 first;
        link_pkg::link_flag_t flag;
    } ring_entry_t;                     // 50 bits

    typedef logic [`HB_RING_AW-1:0] ring_ptr_t;   // wraps at ring depth

    typedef logic [7:0] delay_cnt_t;    // start delay countdown

    // raster sequencing
    typedef enum logic [1:0] {
        RASTER_IDLE  = 2'd0,            // no marker yet, outputs low
        RASTER_DELAY = 2'd1,            // counting down start delay
        RASTER_RUN   = 2'd2             // counters free running
    } raster_state_t;

endpackage : video_pkg

`default_nettype wire

//--- files.f
+incdir+common
+incdir+verification
common/link_pkg.sv
common/video_pkg.sv
common/pixel_ring_if.sv
src/link_word_decoder.sv
pixel_store/pixel_ring.sv
pixel_store/pixel_unpacker.sv
src/video_timing_gen.sv
src/axi_to_hdmi_top.sv
verification/tb_axi_to_hdmi.sv

//--- pixel_store/pixel_ring.sv
/* 16-entry ring queue of pixel entries
   wrapping pointers, full/empty flags, frame clear */
`default_nettype none

`include "hdmi_bridge_config.svh"

module pixel_ring (
    input  wire logic pixel_clk,
    input  wire logic rst_n,
    pixel_ring_if.store q
);
    import video_pkg::*;

    ring_entry_t mem [`HB_RING_DEPTH];   // entry storage
    ring_ptr_t   wr_ptr;
    ring_ptr_t   rd_ptr;
    ring_ptr_t   wr_next;                // wr_ptr + 1, wraps with pointer width
    logic        do_push;
    logic        do_pop;

    assign wr_next = wr_ptr + 1'b1;

    // one slot kept free, 15 usable
    assign q.full  = (wr_next == rd_ptr);
    assign q.empty = (wr_ptr == rd_ptr);
    assign q.head  = mem[rd_ptr];        // visible the cycle after the push

    // clear beats both sides
    assign do_push = q.push && !q.full && !q.clear;
    assign do_pop  = q.pop && !q.empty && !q.clear;

    // ========================================
    // pointers
    // ========================================
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (q.clear) begin
            wr_ptr <= '0;                // stale entries are simply unreachable
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_next;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge pixel_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= q.push_entry;
        end
    end

endmodule : pixel_ring

`default_nettype wire

//--- pixel_store/pixel_unpacker.sv
/* queue entry to pixel stream, one pixel per de cycle
   dual entries give first then second pixel before the pop */
`default_nettype none

`include "hdmi_bridge_config.svh"

module pixel_unpacker (
    input  wire logic   pixel_clk,
    input  wire logic   rst_n,
    input  wire logic   pixel_req,   // video de
    output video_pkg::rgb_t pixel,
    pixel_ring_if.reader q
);
    import video_pkg::*;

    logic sel;          // 1: second half of a dual entry is next
    logic is_dual;
    logic take;         // a pixel leaves this cycle

    assign is_dual = (q.head.flag == `HB_FLAG_DUAL);
    assign take    = pixel_req && !q.empty;

    // straight from head, no register
    always_comb begin
        if (!take) begin
            pixel = '0;                       // black on underrun or blanking
        end else if (is_dual && sel) begin
            pixel = q.head.second;
        end else begin
            pixel = q.head.first;
        end
    end

    // single: pop now, dual: pop after second pixel
    assign q.pop = take && (!is_dual || sel);

    // ========================================
    // selection bit
    // ========================================
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= 1'b0;
        end else if (q.clear) begin
            sel <= 1'b0;                      // new frame starts on first half
        end else if (take && is_dual) begin
            sel <= !sel;
        end
    end

endmodule : pixel_unpacker

`default_nettype wire

//--- src/axi_to_hdmi_top.sv
/* video output bridge top level
   link decoder, ring queue, unpacker and raster generator */
`default_nettype none

`include "hdmi_bridge_config.svh"

module axi_to_hdmi_top #(
    parameter int H_SYNC  = `HB_H_SYNC,
    parameter int H_BACK  = `HB_H_BACK,
    parameter int H_DISP  = `HB_H_DISP,
    parameter int H_TOTAL = `HB_H_TOTAL,
    parameter int V_SYNC  = `HB_V_SYNC,
    parameter int V_BACK  = `HB_V_BACK,
    parameter int V_DISP  = `HB_V_DISP,
    parameter int V_TOTAL = `HB_V_TOTAL
) (
    input  wire logic                 pixel_clk,
    input  wire logic                 rst_n,
    input  wire logic                 link_valid,   // no back-pressure
    input  wire link_pkg::link_word_t link_data,
    output logic                      video_hs,
    output logic                      video_vs,
    output logic                      video_de,
    output video_pkg::rgb_t           video_rgb
);

    logic marker_seen;      // decoder to raster start

    pixel_ring_if ring_bus ();

    // ========================================
    // link side
    // ========================================
    link_word_decoder decoder_i (
        .pixel_clk   (pixel_clk),
        .rst_n       (rst_n),
        .link_valid  (link_valid),
        .link_data   (link_data),
        .video_vs    (video_vs),    // window follows generated vs
        .marker_seen (marker_seen),
        .ring        (ring_bus.writer)
    );

    pixel_ring ring_i (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .q         (ring_bus.store)
    );

    // ========================================
    // video side
    // ========================================
    pixel_unpacker unpacker_i (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .pixel_req (video_de),
        .pixel     (video_rgb),
        .q         (ring_bus.reader)
    );

    video_timing_gen #(
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .H_DISP  (H_DISP),
        .H_TOTAL (H_TOTAL),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK),
        .V_DISP  (V_DISP),
        .V_TOTAL (V_TOTAL)
    ) timing_i (
        .pixel_clk   (pixel_clk),
        .rst_n       (rst_n),
        .marker_seen (marker_seen),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .video_de    (video_de)
    );

endmodule : axi_to_hdmi_top

`default_nettype wire

//--- src/link_word_decoder.sv
/* link word classifier, frame window tracking
   pushes pixel words into the ring and flags frame markers */
`default_nettype none

`include "hdmi_bridge_config.svh"

module link_word_decoder (
    input  wire logic                 pixel_clk,
    input  wire logic                 rst_n,
    input  wire logic                 link_valid,
    input  wire link_pkg::link_word_t link_data,
    input  wire logic                 video_vs,     // generated vs, fed back
    output logic                      marker_seen,  // one-cycle pulse
    pixel_ring_if.writer              ring
);
    import link_pkg::*;
    import video_pkg::*;

    link_flag_t  word_flag;
    marker_t     word_marker;
    logic        is_marker;
    logic        is_pixel;
    logic        vs_prev;       // vs one cycle back
    logic        vs_rise;
    logic        vs_fall;
    logic        window;        // words accepted while high
    logic        pend_valid;    // registered pixel word waiting for the ring
    ring_entry_t pend_entry;
    logic        clear_q;

    // ========================================
    // word classification
    // ========================================
    assign word_flag   = link_data[15:14];
    assign word_marker = link_data[63:16];

    assign is_marker = link_valid && (word_marker == `HB_MARKER_PATTERN)
                       && (word_flag == `HB_FLAG_MARKER);
    assign is_pixel  = link_valid
                       && ((word_flag == `HB_FLAG_SINGLE) || (word_flag == `HB_FLAG_DUAL));

    // vs edges as seen on this clock
    assign vs_rise = video_vs && !vs_prev;
    assign vs_fall = !video_vs && vs_prev;

    // ========================================
    // window, clear and marker pulse
    // ========================================
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_prev     <= 1'b0;
            window      <= 1'b0;
            clear_q     <= 1'b0;
            marker_seen <= 1'b0;
            pend_valid  <= 1'b0;
        end else begin
            vs_prev     <= video_vs;
            clear_q     <= vs_fall;               // flush right after vs drops
            marker_seen <= is_marker;             // timing gen ignores it outside idle
            if (vs_fall) begin
                window <= 1'b0;
            end else if (vs_rise) begin
                window <= 1'b1;                   // open from next cycle
            end
            pend_valid <= is_pixel && window;     // words outside window are lost
        end
    end

    // payload, packed second/first/flag
    always_ff @(posedge pixel_clk) begin
        if (is_pixel) begin
            pend_entry.second <= link_data[63:40];
            pend_entry.first  <= link_data[39:16];
            pend_entry.flag   <= word_flag;
        end
    end

    // drop the word if the queue has no room this cycle
    assign ring.push       = pend_valid && !ring.full;
    assign ring.push_entry = pend_entry;
    assign ring.clear      = clear_q;

endmodule : link_word_decoder

`default_nettype wire

//--- src/video_timing_gen.sv
/* raster sequencer, start delay after first marker
   h/v counters and registered hs, vs, de */
`default_nettype none

`include "hdmi_bridge_config.svh"

module video_timing_gen #(
    parameter int H_SYNC  = `HB_H_SYNC,
    parameter int H_BACK  = `HB_H_BACK,
    parameter int H_DISP  = `HB_H_DISP,
    parameter int H_TOTAL = `HB_H_TOTAL,
    parameter int V_SYNC  = `HB_V_SYNC,
    parameter int V_BACK  = `HB_V_BACK,
    parameter int V_DISP  = `HB_V_DISP,
    parameter int V_TOTAL = `HB_V_TOTAL
) (
    input  wire logic pixel_clk,
    input  wire logic rst_n,
    input  wire logic marker_seen,
    output logic      video_hs,
    output logic      video_vs,
    output logic      video_de
);
    import video_pkg::*;

    // counter limits at counter width
    localparam coord_t H_SYNC_C   = coord_t'(H_SYNC);
    localparam coord_t H_DE_START = coord_t'(H_SYNC + H_BACK);
    localparam coord_t H_DE_END   = coord_t'(H_SYNC + H_BACK + H_DISP);
    localparam coord_t H_LAST     = coord_t'(H_TOTAL - 1);
    localparam coord_t V_SYNC_C   = coord_t'(V_SYNC);
    localparam coord_t V_DE_START = coord_t'(V_SYNC + V_BACK);
    localparam coord_t V_DE_END   = coord_t'(V_SYNC + V_BACK + V_DISP);
    localparam coord_t V_LAST     = coord_t'(V_TOTAL - 1);

    localparam delay_cnt_t DELAY_LOAD = delay_cnt_t'(`HB_START_DELAY - 1);

    raster_state_t state;
    delay_cnt_t    delay_cnt;
    coord_t        h_cnt;
    coord_t        v_cnt;
    logic          h_active;
    logic          v_active;

    // ========================================
    // start sequencing
    // ========================================
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RASTER_IDLE;
            delay_cnt <= '0;
        end else begin
            case (state)
                RASTER_IDLE: begin
                    if (marker_seen) begin
                        state     <= RASTER_DELAY;
                        delay_cnt <= DELAY_LOAD;
                    end
                end
                RASTER_DELAY: begin
                    if (delay_cnt == '0) begin
                        state <= RASTER_RUN;      // start delay cycles spent here
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                RASTER_RUN: begin
                    state <= RASTER_RUN;          // runs until reset, later markers ignored
                end
                default: begin
                    state <= RASTER_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // raster counters
    // ========================================
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (state != RASTER_RUN) begin
            h_cnt <= '0;                          // first line starts at h 0, v 0
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_active = (h_cnt >= H_DE_START) && (h_cnt < H_DE_END);
    assign v_active = (v_cnt >= V_DE_START) && (v_cnt < V_DE_END);

    // sync pulses are active low, one cycle behind the counters
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end else if (state == RASTER_RUN) begin
            video_hs <= (h_cnt >= H_SYNC_C);
            video_vs <= (v_cnt >= V_SYNC_C);
            video_de <= h_active && v_active;
        end else begin
            video_hs <= 1'b0;                     // all low until the raster runs
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end
    end

endmodule : video_timing_gen

`default_nettype wire

//--- verification/tb_video_model.svh
/* testbench reference model of the bridge
   pixel queue, selection bit, frame window and raster position */
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

// edges from the sampled marker to the first raster output
// marker register, leaving idle, then the start delay itself
localparam int FIRST_OUT = 2 + `HB_START_DELAY;
localparam int RING_ROOM = `HB_RING_DEPTH - 1;     // one slot always kept free

int          start_edges;     // -1 until a marker starts the raster
int          frames_seen;     // rising vs edges so far
logic        m_vs_prev;
logic        m_window;        // pixel words accepted while high
logic        m_clear;         // flush due at the next edge
logic        m_pend_valid;    // word waiting one cycle before the push
logic [48:0] m_pend;          // {dual, second, first}
logic        m_sel;           // second half of a dual entry is next
logic [48:0] m_queue [$];

task automatic model_reset();
    start_edges  = -1;
    frames_seen  = 0;
    m_vs_prev    = 1'b0;
    m_window     = 1'b0;
    m_clear      = 1'b0;
    m_pend_valid = 1'b0;
    m_pend       = '0;
    m_sel        = 1'b0;
    m_queue.delete();
endtask

// outputs for the current cycle
task automatic expected_video(output logic hs, output logic vs, output logic de,
                              output logic [23:0] rgb);
    int pos;
    int h;
    int v;
    hs  = 1'b0;
    vs  = 1'b0;
    de  = 1'b0;
    rgb = '0;                                   // black unless a pixel is due
    if (start_edges >= FIRST_OUT) begin
        pos = (start_edges - FIRST_OUT) % (TB_H_TOTAL * TB_V_TOTAL);
        h   = pos % TB_H_TOTAL;
        v   = pos / TB_H_TOTAL;
        hs  = (h >= TB_H_SYNC);                 // sync is active low
        vs  = (v >= TB_V_SYNC);
        de  = (h >= TB_H_SYNC + TB_H_BACK) && (h < TB_H_SYNC + TB_H_BACK + TB_H_DISP)
              && (v >= TB_V_SYNC + TB_V_BACK) && (v < TB_V_SYNC + TB_V_BACK + TB_V_DISP);
    end
    if (de && (m_queue.size() > 0)) begin
        rgb = (m_queue[0][48] && m_sel) ? m_queue[0][47:24] : m_queue[0][23:0];
    end
endtask

// effects of one rising edge in the order clear, pop, push
task automatic model_edge(input logic valid, input logic [63:0] data,
                          input logic vs_now, input logic de_now);
    logic [1:0]  flag;
    logic        is_pixel;
    logic        was_full;
    flag     = data[15:14];
    was_full = (m_queue.size() == RING_ROOM);   // full is judged before the pop
    if (m_clear) begin
        m_queue.delete();                       // leftovers of the old frame
        m_sel = 1'b0;
    end else begin
        if (de_now && (m_queue.size() > 0)) begin
            if (m_queue[0][48] && !m_sel) begin
                m_sel = 1'b1;
            end else begin
                m_queue.delete(0);
                m_sel = 1'b0;
            end
        end
        if (m_pend_valid && !was_full) begin
            m_queue.push_back(m_pend);
        end
    end
    // word sampled at this edge
    is_pixel     = valid && ((flag == `HB_FLAG_SINGLE) || (flag == `HB_FLAG_DUAL));
    m_pend_valid = is_pixel && m_window;
    if (is_pixel) begin
        m_pend = {(flag == `HB_FLAG_DUAL), data[63:40], data[39:16]};
    end
    m_clear = !vs_now && m_vs_prev;
    if (!vs_now && m_vs_prev) begin
        m_window = 1'b0;
    end else if (vs_now && !m_vs_prev) begin
        m_window    = 1'b1;
        frames_seen = frames_seen + 1;
    end
    m_vs_prev = vs_now;
    if (start_edges >= 0) begin
        start_edges = start_edges + 1;
    end else if (valid && (data[63:16] == `HB_MARKER_PATTERN)
                 && (flag == `HB_FLAG_MARKER)) begin
        start_edges = 0;                        // only the first marker counts
    end
endtask

`endif

//--- verification/tb_axi_to_hdmi.sv
/* testbench for the video output bridge
   seeded random link words, reference model checks, watchdog */
`default_nettype none

`include "hdmi_bridge_config.svh"

module tb_axi_to_hdmi;
    import link_pkg::*;
    import video_pkg::*;

    // small raster so a run covers several frames
    localparam int TB_H_SYNC    = 4;
    localparam int TB_H_BACK    = 6;
    localparam int TB_H_DISP    = 16;
    localparam int TB_H_TOTAL   = 30;
    localparam int TB_V_SYNC    = 2;
    localparam int TB_V_BACK    = 2;
    localparam int TB_V_DISP    = 4;
    localparam int TB_V_TOTAL   = 9;
    localparam int CLK_PERIOD   = 10;
    localparam int NUM_FRAMES   = 8;
    localparam int TIMEOUT      = (NUM_FRAMES + 2) * TB_H_TOTAL * TB_V_TOTAL * CLK_PERIOD
                                  + `HB_START_DELAY * CLK_PERIOD;

    logic       pixel_clk;
    logic       rst_n;
    logic       link_valid;
    link_word_t link_data;
    logic       video_hs;
    logic       video_vs;
    logic       video_de;
    rgb_t       video_rgb;
    integer     seed;
    int         wait_cycles;

    `include "tb_video_model.svh"

    axi_to_hdmi_top #(
        .H_SYNC  (TB_H_SYNC),
        .H_BACK  (TB_H_BACK),
        .H_DISP  (TB_H_DISP),
        .H_TOTAL (TB_H_TOTAL),
        .V_SYNC  (TB_V_SYNC),
        .V_BACK  (TB_V_BACK),
        .V_DISP  (TB_V_DISP),
        .V_TOTAL (TB_V_TOTAL)
    ) dut_i (
        .pixel_clk  (pixel_clk),
        .rst_n      (rst_n),
        .link_valid (link_valid),
        .link_data  (link_data),
        .video_hs   (video_hs),
        .video_vs   (video_vs),
        .video_de   (video_de),
        .video_rgb  (video_rgb)
    );

    // ========================================
    // clock and watchdog
    // ========================================
    initial begin
        pixel_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Something failed");
        $fatal(1, "run timed out before %0d frames were shown", NUM_FRAMES);
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // pixel, junk or marker word; markers only when allowed
    function automatic link_word_t random_word(input logic allow_marker);
        link_word_t w;
        int         kind;
        w    = {$random(seed), $random(seed)};
        kind = $random(seed) & 15;
        if (kind < 6) begin
            w[15:14] = `HB_FLAG_SINGLE;
        end else if (kind < 12) begin
            w[15:14] = `HB_FLAG_DUAL;
        end else if (kind < 14) begin
            w[15:14] = 2'b00;                      // unknown kind, ignored
        end else if ((kind == 14) || !allow_marker) begin
            w[15:14] = 2'b11;                      // flag of a marker, wrong pattern
            if (w[63:16] == `HB_MARKER_PATTERN) begin
                w[16] = ~w[16];
            end
        end else begin
            w[63:16] = `HB_MARKER_PATTERN;
            w[15:14] = `HB_FLAG_MARKER;
        end
        return w;
    endfunction

    // check this cycle, then drive the word for the next rising edge
    task automatic next_cycle(input logic valid, input link_word_t word);
        logic        exp_hs;
        logic        exp_vs;
        logic        exp_de;
        logic [23:0] exp_rgb;
        @(negedge pixel_clk);
        expected_video(exp_hs, exp_vs, exp_de, exp_rgb);
        check_value(video_hs, exp_hs, "video_hs");
        check_value(video_vs, exp_vs, "video_vs");
        check_value(video_de, exp_de, "video_de");
        check_value(video_rgb, exp_rgb, "video_rgb");
        link_valid = valid;
        link_data  = word;                         // data changes even without valid
        model_edge(valid, word, exp_vs, exp_de);
    endtask

    // density 0..8 out of 8 cycles carry a valid word
    task automatic random_cycle(input int density, input logic allow_marker);
        logic       valid;
        link_word_t word;
        valid = (($random(seed) & 7) < density);
        word  = random_word(allow_marker);
        next_cycle(valid, word);
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        seed       = 32'h7c8e43be;
        rst_n      = 1'b0;
        link_valid = 1'b0;
        link_data  = '0;
        model_reset();
        repeat (4) @(posedge pixel_clk);
        @(negedge pixel_clk);
        rst_n = 1'b1;

        // no marker yet, raster must stay dark
        repeat (40) random_cycle(5, 1'b0);

        next_cycle(1'b1, {`HB_MARKER_PATTERN, `HB_FLAG_MARKER, 14'h0});
        wait_cycles = 0;
        while (video_vs !== 1'b1) begin
            random_cycle(3, 1'b0);
            wait_cycles = wait_cycles + 1;
        end
        check_value(wait_cycles > `HB_START_DELAY, 1, "vs rose before the start delay");

        // frames with varying load, from underrun to overflow, markers ignored
        while (frames_seen < NUM_FRAMES) begin
            random_cycle((frames_seen * 5) % 9, 1'b1);
        end

        $display("Everything OK");
        $finish;
    end

endmodule : tb_axi_to_hdmi

`default_nettype wire
